// File: Makefile
.PHONY: simulate clean

simulate:
	verilator --binary --timing --top-module tb_dodge_top -f filelist.f
	./obj_dir/Vtb_dodge_top | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// File: common/dodge_pkg.sv
//==========================================================================
// Shared types and constants of the two-player dodging game on an 8x8 field
// Modules take these through a wildcard import in their module header
//==========================================================================
`default_nettype none

package dodge_pkg;

	// Field is square, rows and columns alike
	localparam int FIELD_ROWS = 8;

	// One field row, or a player as a one-hot column mask
	typedef logic [FIELD_ROWS-1:0] row_t;

	// Row or column index
	typedef logic [$clog2(FIELD_ROWS)-1:0] row_idx_t;

	// Point count, saturates at all ones
	typedef logic [7:0] score_t;

	typedef enum logic [1:0] {
		IDLE,
		PLAY,
		OVER
	} game_state_e;

	typedef struct packed {
		row_t p1;
		row_t p2;
	} player_pos_t;

	typedef struct packed {
		logic left;
		logic right;
	} buttons_t;

	// Control from the judge to all stepping stages
	typedef struct packed {
		logic playing;
		logic restart;
	} game_ctrl_t;

	// Row 0 is the bottom row, where the players sit
	typedef row_t [FIELD_ROWS-1:0] field_t;

	localparam row_t LFSR_SEED = 8'h01;

endpackage

`default_nettype wire

// File: design/dodge_top.sv
//==========================================================================
// Top level of the dodging game
// Connects the step timer, both players, the field, the judge and the
// matrix readout. STEP_CYCLES sets the game speed in clock cycles
//==========================================================================
`default_nettype none

module dodge_top import dodge_pkg::*; #(
	parameter int STEP_CYCLES = 16
) (
	input  logic        clock_50,
	input  logic        arst_n,
	input  logic        start,
	input  buttons_t    buttons_1,
	input  buttons_t    buttons_2,
	input  row_idx_t    disp_addr,
	output row_t        disp_data,
	output game_state_e state,
	output score_t      score,
	output logic [1:0]  alive
);

	game_ctrl_t  ctrl;
	logic        step;
	logic        scrolled;
	row_t        pos_1;
	row_t        pos_2;
	player_pos_t pos;
	field_t      field;
	row_t        bottom;

	assign pos = '{p1: pos_1, p2: pos_2};

	//==========================================================================
	// Timer stage
	//==========================================================================
	step_timer #(
		.STEP_CYCLES(STEP_CYCLES)
	) i_step_timer (
		.clock_50(clock_50),
		.arst_n  (arst_n),
		.ctrl    (ctrl),
		.step    (step)
	);

	//==========================================================================
	// Player and field stage
	//==========================================================================
	player_ctrl #(
		.INIT_POS(8'b01000000)
	) i_player_ctrl_1 (
		.clock_50(clock_50),
		.arst_n  (arst_n),
		.ctrl    (ctrl),
		.step    (step),
		.buttons (buttons_1),
		.pos     (pos_1)
	);

	player_ctrl #(
		.INIT_POS(8'b00000100)
	) i_player_ctrl_2 (
		.clock_50(clock_50),
		.arst_n  (arst_n),
		.ctrl    (ctrl),
		.step    (step),
		.buttons (buttons_2),
		.pos     (pos_2)
	);

	field_scroll i_field_scroll (
		.clock_50(clock_50),
		.arst_n  (arst_n),
		.ctrl    (ctrl),
		.step    (step),
		.field   (field),
		.bottom  (bottom),
		.scrolled(scrolled)
	);

	//==========================================================================
	// Judge stage and display
	//==========================================================================
	collision_judge i_collision_judge (
		.clock_50(clock_50),
		.arst_n  (arst_n),
		.start   (start),
		.scrolled(scrolled),
		.bottom  (bottom),
		.pos     (pos),
		.ctrl    (ctrl),
		.state   (state),
		.score   (score),
		.alive   (alive)
	);

	matrix_readout i_matrix_readout (
		.field    (field),
		.pos      (pos),
		.disp_addr(disp_addr),
		.disp_data(disp_data)
	);

endmodule

`default_nettype wire

// File: design/matrix_readout.sv
//==========================================================================
// Column readout for the LED matrix driver
// Players are merged into the bottom row. One address returns one column,
// bottom row in the MSB and top row in the LSB
//==========================================================================
`default_nettype none

module matrix_readout import dodge_pkg::*; (
	input  field_t      field,
	input  player_pos_t pos,
	input  row_idx_t    disp_addr,
	output row_t        disp_data
);

	field_t   shown;
	row_idx_t col;

	// Address 0 reads the leftmost column, bit 7
	assign col = row_idx_t'(FIELD_ROWS - 1) - disp_addr;

	always_comb begin
		shown    = field;
		shown[0] = field[0] | pos.p1 | pos.p2;
		for (int r = 0; r < FIELD_ROWS; r++) begin
			disp_data[FIELD_ROWS-1-r] = shown[r][col];
		end
	end

endmodule

`default_nettype wire

// File: design/player_ctrl.sv
//==========================================================================
// Position register of one player
// Moves a one-hot column mask on each step, bounded by the field edges
//==========================================================================
`default_nettype none

module player_ctrl import dodge_pkg::*; #(
	parameter row_t INIT_POS = 8'b01000000
) (
	input  logic       clock_50,
	input  logic       arst_n,
	input  game_ctrl_t ctrl,
	input  logic       step,
	input  buttons_t   buttons,
	output row_t       pos
);

	logic go_left;
	logic go_right;

	// Only a single button moves, and never past an edge
	assign go_left  = buttons.left && !buttons.right && !pos[FIELD_ROWS-1];
	assign go_right = buttons.right && !buttons.left && !pos[0];

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			pos <= INIT_POS;
		end else if (ctrl.restart) begin
			pos <= INIT_POS;
		end else if (step && ctrl.playing) begin
			if (go_left) begin
				pos <= pos << 1;
			end else if (go_right) begin
				pos <= pos >> 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/step_timer.sv
//==========================================================================
// Game step timer
// Counts clock cycles while a game runs and pulses step once per period
//==========================================================================
`default_nettype none

module step_timer import dodge_pkg::*; #(
	parameter int STEP_CYCLES = 16
) (
	input  logic       clock_50,
	input  logic       arst_n,
	input  game_ctrl_t ctrl,
	output logic       step
);

	localparam int CNT_W = $clog2(STEP_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(STEP_CYCLES - 1);

	logic [CNT_W-1:0] count;

	// Frozen outside PLAY, restarted from zero on a new game
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (ctrl.restart) begin
			count <= '0;
		end else if (ctrl.playing) begin
			if (count == CNT_LAST) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	// First pulse lands STEP_CYCLES cycles after the restart cycle
	assign step = ctrl.playing && !ctrl.restart && (count == CNT_LAST);

endmodule

`default_nettype wire

// File: filelist.f
common/dodge_pkg.sv
design/step_timer.sv
design/player_ctrl.sv
game/field_scroll.sv
game/collision_judge.sv
design/matrix_readout.sv
design/dodge_top.sv
tb/tb_dodge_top.sv

// File: game/collision_judge.sv
//==========================================================================
// Game FSM and referee
// Starts and restarts games, checks both players against the bottom row
// after every scroll, and keeps the score and the alive flags
//==========================================================================
`default_nettype none

module collision_judge import dodge_pkg::*; (
	input  logic        clock_50,
	input  logic        arst_n,
	input  logic        start,
	input  logic        scrolled,
	input  row_t        bottom,
	input  player_pos_t pos,
	output game_ctrl_t  ctrl,
	output game_state_e state,
	output score_t      score,
	output logic [1:0]  alive
);

	logic   restart;
	logic   hit_1;
	logic   hit_2;

	assign hit_1     = |(pos.p1 & bottom);
	assign hit_2     = |(pos.p2 & bottom);

	//==========================================================================
	// State machine, score and alive flags
	// alive[0] is player 1, alive[1] is player 2
	//==========================================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state   <= IDLE;
			restart <= 1'b0;
			score   <= '0;
			alive   <= 2'b11;
		end else begin
			restart <= 1'b0;
			unique case (state)
				IDLE, OVER: begin
					if (start) begin
						state   <= PLAY;
						restart <= 1'b1;
					end
				end
				PLAY: begin
					if (restart) begin
						score <= '0;
						alive <= 2'b11;
					end else if (scrolled) begin
						if (hit_1 || hit_2) begin
							state    <= OVER;
							alive[0] <= !hit_1;
							alive[1] <= !hit_2;
						end else if (score != '1) begin
							score <= score + 1'b1;
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Playing also covers the restart cycle
	assign ctrl.playing = (state == PLAY);
	assign ctrl.restart = restart;

endmodule

`default_nettype wire

// File: game/field_scroll.sv
//==========================================================================
// Scrolling obstacle field
// Eight row registers fed at the top by an 8-bit Fibonacci LFSR. Each step
// moves every row down by one and loads a fresh random row into row 7
//==========================================================================
`default_nettype none

module field_scroll import dodge_pkg::*; (
	input  logic       clock_50,
	input  logic       arst_n,
	input  game_ctrl_t ctrl,
	input  logic       step,
	output field_t     field,
	output row_t       bottom,
	output logic       scrolled
);

	row_t lfsr;
	row_t lfsr_next;

	// Taps 7, 5, 4, 3 shifted in at the LSB
	assign lfsr_next = {lfsr[FIELD_ROWS-2:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};

	//==========================================================================
	// Random row generator
	//==========================================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			lfsr <= LFSR_SEED;
		end else if (ctrl.restart) begin
			lfsr <= LFSR_SEED;
		end else if (step && ctrl.playing) begin
			lfsr <= lfsr_next;
		end
	end

	//==========================================================================
	// Row registers
	//==========================================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			field <= '0;
		end else if (ctrl.restart) begin
			field <= '0;
		end else if (step && ctrl.playing) begin
			for (int r = 0; r < FIELD_ROWS - 1; r++) begin
				field[r] <= field[r+1];
			end
			field[FIELD_ROWS-1] <= lfsr_next;
		end
	end

	// Tells the judge the field has moved
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			scrolled <= 1'b0;
		end else begin
			scrolled <= step;
		end
	end

	assign bottom = field[0];

endmodule

`default_nettype wire

// File: tb/dodge_patterns.txt
# s: pulse start for one cycle
# m <p1 left,right> <p2 left,right> <expected p1 hex> <expected p2 hex>
s
m 10 01 80 02
m 10 01 80 01
m 11 01 80 01
m 01 11 40 01
m 01 10 20 02
m 00 10 20 04
m 00 00 20 04
m 00 00 20 04
m 00 00 20 04
m 10 01 20 04
m 01 10 20 04
s
m 01 00 20 04
m 01 00 10 04
m 01 00 08 04
m 01 00 04 04
m 01 01 02 02
m 00 00 02 02
m 00 00 02 02
m 00 00 02 02
m 10 01 02 02

// File: tb/tb_dodge_top.sv
//==========================================================================
// Self-checking testbench for the dodging game top level
// Replays start and button lines from tb/dodge_patterns.txt, rebuilds the
// field, score and alive flags in a model and compares after every step
//==========================================================================
`default_nettype none

module tb_dodge_top import dodge_pkg::*; ();

	localparam int   STEP_CYCLES = 16;
	localparam int   CLK_PERIOD  = 40;
	localparam row_t P1_INIT     = 8'b01000000;
	localparam row_t P2_INIT     = 8'b00000100;

	logic        clock_50;
	logic        arst_n;
	logic        start;
	buttons_t    buttons_1;
	buttons_t    buttons_2;
	row_idx_t    disp_addr;
	row_t        disp_data;
	game_state_e state;
	score_t      score;
	logic [1:0]  alive;

	// Pattern lines, one entry per s or m line
	logic [7:0] kind_q[$];
	logic [1:0] btn1_q[$];
	logic [1:0] btn2_q[$];
	row_t       exp1_q[$];
	row_t       exp2_q[$];
	logic       loaded;

	// Reference model
	row_t        m_lfsr;
	field_t      m_field;
	row_t        m_p1;
	row_t        m_p2;
	score_t      m_score;
	logic [1:0]  m_alive;
	game_state_e m_state;

	int errors;
	int tests;
	int failed_tests;

	initial clock_50 = 1'b0;
	always #(CLK_PERIOD / 2) clock_50 = ~clock_50;

	dodge_top #(
		.STEP_CYCLES(STEP_CYCLES)
	) i_dodge_top (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.start    (start),
		.buttons_1(buttons_1),
		.buttons_2(buttons_2),
		.disp_addr(disp_addr),
		.disp_data(disp_data),
		.state    (state),
		.score    (score),
		.alive    (alive)
	);

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// Eight column reads, turned back into rows
	task automatic read_field(output field_t rows);
		rows = '0;
		for (int a = 0; a < FIELD_ROWS; a++) begin
			disp_addr = row_idx_t'(a);
			#1;
			for (int r = 0; r < FIELD_ROWS; r++) begin
				rows[r][FIELD_ROWS-1-a] = disp_data[FIELD_ROWS-1-r];
			end
		end
		disp_addr = '0;
	endtask

	task automatic compare_dut(input string name);
		field_t got;
		field_t want;
		read_field(got);
		want    = m_field;
		want[0] = m_field[0] | m_p1 | m_p2;
		check({name, " bottom row"}, 64'(want[0]), 64'(got[0]));
		check({name, " upper rows"}, 64'(want[FIELD_ROWS-1:1]), 64'(got[FIELD_ROWS-1:1]));
		check({name, " state"}, 64'(m_state), 64'(state));
		check({name, " score"}, 64'(m_score), 64'(score));
		check({name, " alive"}, 64'(m_alive), 64'(alive));
	endtask

	task automatic clear_model(input game_state_e st);
		m_lfsr  = LFSR_SEED;
		m_field = '0;
		m_p1    = P1_INIT;
		m_p2    = P2_INIT;
		m_score = '0;
		m_alive = 2'b11;
		m_state = st;
	endtask

	// One game step: scroll, new random top row, then the collision rule
	task automatic advance_model(input row_t p1, input row_t p2);
		logic hit_1;
		logic hit_2;
		m_p1 = p1;
		m_p2 = p2;
		if (m_state == PLAY) begin
			m_lfsr = {m_lfsr[6:0], m_lfsr[7] ^ m_lfsr[5] ^ m_lfsr[4] ^ m_lfsr[3]};
			for (int r = 0; r < FIELD_ROWS - 1; r++) begin
				m_field[r] = m_field[r+1];
			end
			m_field[FIELD_ROWS-1] = m_lfsr;
			hit_1 = |(m_p1 & m_field[0]);
			hit_2 = |(m_p2 & m_field[0]);
			if (hit_1 || hit_2) begin
				m_state = OVER;
				m_alive = {!hit_2, !hit_1};
			end else if (m_score != 8'hff) begin
				m_score = m_score + 8'd1;
			end
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("ok      %s", name);
		end else begin
			failed_tests++;
			$display("errors  %s", name);
		end
	endtask

	//==========================================================================
	// Pattern replay
	//==========================================================================
	initial begin
		int         fd;
		int         n_fields;
		int         bad;
		int         game;
		int         step_no;
		string      line;
		string      name;
		logic [1:0] b1;
		logic [1:0] b2;
		row_t       e1;
		row_t       e2;
		start     = 1'b0;
		buttons_1 = '0;
		buttons_2 = '0;
		disp_addr = '0;
		arst_n    = 1'b0;
		errors    = 0;
		tests     = 0;
		failed_tests = 0;
		loaded    = 1'b0;
		game      = 0;
		step_no   = 0;
		fd = $fopen("tb/dodge_patterns.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the pattern file tb/dodge_patterns.txt");
			errors++;
		end
		while (fd != 0 && !$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line.getc(0) == "s") begin
				kind_q.push_back("s");
				btn1_q.push_back(2'b00);
				btn2_q.push_back(2'b00);
				exp1_q.push_back(P1_INIT);
				exp2_q.push_back(P2_INIT);
			end else if (line.len() > 0 && line.getc(0) == "m") begin
				n_fields = $sscanf(line, "m %b %b %h %h", b1, b2, e1, e2);
				if (n_fields != 4) begin
					$display("Malformed pattern line: %s", line);
					errors++;
				end
				kind_q.push_back("m");
				btn1_q.push_back(b1);
				btn2_q.push_back(b2);
				exp1_q.push_back(e1);
				exp2_q.push_back(e2);
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		if (kind_q.size() == 0) begin
			$display("No pattern lines were found in the pattern file");
			errors++;
		end
		loaded = 1'b1;

		// Four cycles of reset, released on a falling edge
		repeat (4) @(negedge clock_50);
		arst_n = 1'b1;
		clear_model(IDLE);
		bad = errors;
		compare_dut("reset");
		report_test("reset", bad);
		@(negedge clock_50);

		for (int i = 0; i < kind_q.size(); i++) begin
			bad = errors;
			if (kind_q[i] == "s") begin
				game++;
				step_no = 0;
				start = 1'b1;
				@(negedge clock_50);
				start = 1'b0;
				// Restart is done, first step not yet taken
				repeat (STEP_CYCLES - 1) @(negedge clock_50);
				clear_model(PLAY);
				name = $sformatf("game %0d start", game);
			end else begin
				step_no++;
				buttons_1 = buttons_t'(btn1_q[i]);
				buttons_2 = buttons_t'(btn2_q[i]);
				// Sampled just before the next step pulse
				repeat (STEP_CYCLES - 1) @(negedge clock_50);
				advance_model(exp1_q[i], exp2_q[i]);
				name = $sformatf("game %0d step %0d", game, step_no);
			end
			compare_dut(name);
			report_test(name, bad);
			@(negedge clock_50);
		end

		$display("%0d tests run, %0d clean, %0d with errors, %0d mismatches in total",
			tests, tests - failed_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog sized from the number of pattern lines
	initial begin
		wait (loaded);
		#((kind_q.size() + 10) * STEP_CYCLES * CLK_PERIOD);
		$display("Watchdog timeout, the pattern replay did not finish in time");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
